// ==== source/axi_demux_pkg.sv ====
// ---------------------------------------------------------
// AXI write demux shared definitions
// ---------------------------------------------------------

package axi_demux_pkg;

  // ---------------------------------------------------------
  // Configuration
  // ---------------------------------------------------------
  localparam int unsigned NUM_MST_PORTS   = 4;
  localparam int unsigned ID_WIDTH        = 4;
  localparam int unsigned ID_LOOK_BITS    = 2;
  localparam int unsigned NUM_ID_COUNTERS = 2 ** ID_LOOK_BITS;
  // Depth of the W routing FIFO
  localparam int unsigned MAX_TRANS       = 8;
  localparam int unsigned CNT_WIDTH       = 3;
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned DATA_WIDTH      = 32;
  localparam int unsigned LEN_WIDTH       = 8;

  // ---------------------------------------------------------
  // Field types
  // ---------------------------------------------------------
  typedef logic [$clog2(NUM_MST_PORTS)-1:0] select_t;
  typedef logic [ID_WIDTH-1:0]              id_t;
  typedef logic [ID_LOOK_BITS-1:0]          look_id_t;
  typedef logic [CNT_WIDTH-1:0]             cnt_t;
  typedef logic [ADDR_WIDTH-1:0]            addr_t;
  typedef logic [DATA_WIDTH-1:0]            data_t;
  typedef logic [DATA_WIDTH/8-1:0]          strb_t;
  typedef logic [LEN_WIDTH-1:0]             len_t;
  typedef logic [1:0]                       resp_t;

  // Channel payloads
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // AW control FSM
  typedef enum logic {
    AW_IDLE,
    AW_LOCKED
  } aw_state_e;

endpackage

// ==== source/demux_id_table.sv ====
// ---------------------------------------------------------
// Per-ID in-flight counters
// ---------------------------------------------------------
`timescale 1ns/1ps

module demux_id_table (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Lookup for the AW waiting at the slave port
  input  axi_demux_pkg::id_t     lookup_id_i,
  output axi_demux_pkg::select_t lookup_select_o,
  output logic                   lookup_occupied_o,
  output logic                   full_o,
  // Push on AW admission
  input  logic                   push_i,
  input  axi_demux_pkg::id_t     push_id_i,
  input  axi_demux_pkg::select_t push_select_i,
  // Pop on B transfer to the slave
  input  logic                   pop_i,
  input  axi_demux_pkg::id_t     pop_id_i
);
  import axi_demux_pkg::*;

  cnt_t    [NUM_ID_COUNTERS-1:0] cnt_q;
  select_t [NUM_ID_COUNTERS-1:0] select_q;
  logic    [NUM_ID_COUNTERS-1:0] push_en;
  logic    [NUM_ID_COUNTERS-1:0] pop_en;
  logic    [NUM_ID_COUNTERS-1:0] cnt_full;
  look_id_t                      lookup_idx;
  look_id_t                      push_idx;
  look_id_t                      pop_idx;

  // Only the low ID bits take part in ordering
  assign lookup_idx = lookup_id_i[ID_LOOK_BITS-1:0];
  assign push_idx   = push_id_i[ID_LOOK_BITS-1:0];
  assign pop_idx    = pop_id_i[ID_LOOK_BITS-1:0];

  always_comb begin
    for (int i = 0; i < NUM_ID_COUNTERS; i++) begin
      push_en[i]  = push_i && (push_idx == look_id_t'(i));
      pop_en[i]   = pop_i && (pop_idx == look_id_t'(i));
      cnt_full[i] = &cnt_q[i];
    end
  end

  assign lookup_select_o   = select_q[lookup_idx];
  assign lookup_occupied_o = (cnt_q[lookup_idx] != '0);
  assign full_o            = |cnt_full;

  // In-flight counters, push and pop together cancel out
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_ID_COUNTERS; i++) begin
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + cnt_t'(1);
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - cnt_t'(1);
        end
      end
    end
  end

  // Target port of the latest push per ID
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_ID_COUNTERS; i++) begin
      if (push_en[i]) begin
        select_q[i] <= push_select_i;
      end
    end
  end

  // A B response must belong to an AW that is still in flight
  a_no_pop_at_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (cnt_q[pop_idx] != '0)
  ) else $error("B response with ID %0h has no outstanding AW", pop_id_i);

endmodule

// ==== source/demux_aw_control.sv ====
// ---------------------------------------------------------
// AW admission and routing control
// ---------------------------------------------------------
`timescale 1ns/1ps

module demux_aw_control (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  axi_demux_pkg::aw_chan_t                 slv_aw_i,
  input  axi_demux_pkg::select_t                  slv_aw_select_i,
  input  logic                                    slv_aw_valid_i,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_aw_ready_i,
  input  axi_demux_pkg::select_t                  lookup_select_i,
  input  logic                                    lookup_occupied_i,
  input  logic                                    cnt_full_i,
  input  logic                                    fifo_full_i,
  output logic                                    slv_aw_ready_o,
  output axi_demux_pkg::aw_chan_t                 mst_aw_o,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_aw_valid_o,
  output logic                                    aw_push_o
);
  import axi_demux_pkg::*;

  aw_state_e state_q;
  aw_state_e state_d;
  logic      aw_valid;
  logic      aw_ready;
  logic      admit;

  assign aw_ready = mst_aw_ready_i[slv_aw_select_i];

  // Same ID may only go to the port it is already outstanding on
  assign admit = slv_aw_valid_i && !cnt_full_i && !fifo_full_i &&
                 (!lookup_occupied_i || (lookup_select_i == slv_aw_select_i));

  always_comb begin
    state_d        = state_q;
    aw_valid       = 1'b0;
    aw_push_o      = 1'b0;
    slv_aw_ready_o = 1'b0;
    case (state_q)
      AW_IDLE: begin
        if (admit) begin
          aw_valid  = 1'b1;
          // Decision recorded once, even if the master stalls
          aw_push_o = 1'b1;
          if (aw_ready) begin
            slv_aw_ready_o = 1'b1;
          end else begin
            state_d = AW_LOCKED;
          end
        end
      end
      AW_LOCKED: begin
        // Valid stays up until the master takes it
        aw_valid = 1'b1;
        if (aw_ready) begin
          slv_aw_ready_o = 1'b1;
          state_d        = AW_IDLE;
        end
      end
      default: state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Shared payload with the valid only on the selected port
  assign mst_aw_o = slv_aw_i;

  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_aw_valid_o[i] = aw_valid && (slv_aw_select_i == select_t'(i));
    end
  end

  a_select_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    slv_aw_valid_i |-> !$isunknown(slv_aw_select_i)
  ) else $error("AW select names no master port while valid");

  a_aw_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (aw_valid && !aw_ready) |=> aw_valid && $stable(mst_aw_o) && $stable(mst_aw_valid_o)
  ) else $error("Master AW valid or payload changed before the transfer");

endmodule

// ==== source/demux_w_router.sv ====
// ---------------------------------------------------------
// W beat routing by AW order
// ---------------------------------------------------------
`timescale 1ns/1ps

module demux_w_router (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // Routing decisions from the AW side
  input  logic                                    push_i,
  input  axi_demux_pkg::select_t                  push_select_i,
  output logic                                    fifo_full_o,
  // Slave W channel
  input  axi_demux_pkg::w_chan_t                  slv_w_i,
  input  logic                                    slv_w_valid_i,
  output logic                                    slv_w_ready_o,
  // Master W channels
  output axi_demux_pkg::w_chan_t                  mst_w_o,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_w_valid_o,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_w_ready_i
);
  import axi_demux_pkg::*;

  select_t                       fifo_mem [MAX_TRANS];
  logic [$clog2(MAX_TRANS)-1:0]  wr_ptr_q;
  logic [$clog2(MAX_TRANS)-1:0]  rd_ptr_q;
  logic [$clog2(MAX_TRANS):0]    usage_q;
  logic                          fifo_empty;
  logic                          fifo_pop;
  select_t                       w_select;

  // ---------------------------------------------------------
  // Decision FIFO
  // ---------------------------------------------------------
  assign fifo_empty  = (usage_q == '0);
  assign fifo_full_o = (usage_q == MAX_TRANS);
  assign w_select    = fifo_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !fifo_pop) begin
        usage_q <= usage_q + 1'b1;
      end else if (fifo_pop && !push_i) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_mem[wr_ptr_q] <= push_select_i;
    end
  end

  // ---------------------------------------------------------
  // Beat steering
  // ---------------------------------------------------------
  assign mst_w_o       = slv_w_i;
  assign slv_w_ready_o = !fifo_empty && mst_w_ready_i[w_select];
  // Burst done on the last beat transfer
  assign fifo_pop      = slv_w_valid_i && slv_w_ready_o && slv_w_i.last;

  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_w_valid_o[i] = slv_w_valid_i && !fifo_empty && (w_select == select_t'(i));
    end
  end

  // AW control must hold back while the FIFO is full
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !fifo_full_o
  ) else $error("W routing decision pushed into a full FIFO");

endmodule

// ==== source/demux_b_arbiter.sv ====
// ---------------------------------------------------------
// B response round-robin merge
// ---------------------------------------------------------
`timescale 1ns/1ps

module demux_b_arbiter (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  input  axi_demux_pkg::b_chan_t [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_b_i,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_b_valid_i,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_b_ready_o,
  output axi_demux_pkg::b_chan_t                                    slv_b_o,
  output logic                                                      slv_b_valid_o,
  input  logic                                                      slv_b_ready_i,
  output logic                                                      b_fire_o,
  output axi_demux_pkg::id_t                                        b_id_o
);
  import axi_demux_pkg::*;

  logic    lock_q;
  select_t lock_idx_q;
  select_t last_idx_q;
  select_t rr_idx;
  select_t gnt_idx;

  // Search upward from the port after the last winner
  always_comb begin
    select_t cand;
    rr_idx = last_idx_q;
    for (int k = NUM_MST_PORTS; k >= 1; k--) begin
      cand = select_t'(last_idx_q + k);
      if (mst_b_valid_i[cand]) begin
        rr_idx = cand;
      end
    end
  end

  // Locked grant holds while the slave stalls
  assign gnt_idx       = lock_q ? lock_idx_q : rr_idx;
  assign slv_b_valid_o = lock_q ? mst_b_valid_i[lock_idx_q] : |mst_b_valid_i;
  assign slv_b_o       = mst_b_i[gnt_idx];
  assign b_fire_o      = slv_b_valid_o && slv_b_ready_i;
  assign b_id_o        = slv_b_o.id;

  always_comb begin
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_b_ready_o[i] = b_fire_o && (gnt_idx == select_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      // Port 0 wins first after reset
      last_idx_q <= select_t'(NUM_MST_PORTS - 1);
    end else if (b_fire_o) begin
      lock_q     <= 1'b0;
      last_idx_q <= gnt_idx;
    end else if (slv_b_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

// ==== source/axi_write_demux.sv ====
// ---------------------------------------------------------
// AXI write demultiplexer top
// ---------------------------------------------------------
`timescale 1ns/1ps

module axi_write_demux (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  // Slave port
  input  axi_demux_pkg::aw_chan_t                                   slv_aw_i,
  input  axi_demux_pkg::select_t                                    slv_aw_select_i,
  input  logic                                                      slv_aw_valid_i,
  output logic                                                      slv_aw_ready_o,
  input  axi_demux_pkg::w_chan_t                                    slv_w_i,
  input  logic                                                      slv_w_valid_i,
  output logic                                                      slv_w_ready_o,
  output axi_demux_pkg::b_chan_t                                    slv_b_o,
  output logic                                                      slv_b_valid_o,
  input  logic                                                      slv_b_ready_i,
  // Master ports
  output axi_demux_pkg::aw_chan_t                                   mst_aw_o,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_aw_valid_o,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_aw_ready_i,
  output axi_demux_pkg::w_chan_t                                    mst_w_o,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_w_valid_o,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_w_ready_i,
  input  axi_demux_pkg::b_chan_t [axi_demux_pkg::NUM_MST_PORTS-1:0] mst_b_i,
  input  logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_b_valid_i,
  output logic [axi_demux_pkg::NUM_MST_PORTS-1:0]                   mst_b_ready_o
);
  import axi_demux_pkg::*;

  logic    aw_push;
  select_t lookup_select;
  logic    lookup_occupied;
  logic    cnt_full;
  logic    fifo_full;
  logic    b_fire;
  id_t     b_id;

  demux_aw_control aw_control_inst (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .slv_aw_i          (slv_aw_i),
    .slv_aw_select_i   (slv_aw_select_i),
    .slv_aw_valid_i    (slv_aw_valid_i),
    .mst_aw_ready_i    (mst_aw_ready_i),
    .lookup_select_i   (lookup_select),
    .lookup_occupied_i (lookup_occupied),
    .cnt_full_i        (cnt_full),
    .fifo_full_i       (fifo_full),
    .slv_aw_ready_o    (slv_aw_ready_o),
    .mst_aw_o          (mst_aw_o),
    .mst_aw_valid_o    (mst_aw_valid_o),
    .aw_push_o         (aw_push)
  );

  // Lookup and push both use the AW waiting at the slave port
  demux_id_table id_table_inst (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lookup_id_i       (slv_aw_i.id),
    .lookup_select_o   (lookup_select),
    .lookup_occupied_o (lookup_occupied),
    .full_o            (cnt_full),
    .push_i            (aw_push),
    .push_id_i         (slv_aw_i.id),
    .push_select_i     (slv_aw_select_i),
    .pop_i             (b_fire),
    .pop_id_i          (b_id)
  );

  demux_w_router w_router_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (aw_push),
    .push_select_i (slv_aw_select_i),
    .fifo_full_o   (fifo_full),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  demux_b_arbiter b_arbiter_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .b_fire_o      (b_fire),
    .b_id_o        (b_id)
  );

endmodule

// ==== bench/axi_write_demux_tb.sv ====
// ------------------------------------------------------------
// AXI write demux testbench
// ------------------------------------------------------------
`timescale 1ns/1ps

module axi_write_demux_tb;
  import axi_demux_pkg::*;

  localparam int MAX_PATS = 64;

  logic                                clk_i;
  logic                                rst_n_i;
  aw_chan_t                            slv_aw_i;
  select_t                             slv_aw_select_i;
  logic                                slv_aw_valid_i;
  logic                                slv_aw_ready_o;
  w_chan_t                             slv_w_i;
  logic                                slv_w_valid_i;
  logic                                slv_w_ready_o;
  b_chan_t                             slv_b_o;
  logic                                slv_b_valid_o;
  logic                                slv_b_ready_i;
  aw_chan_t                            mst_aw_o;
  logic [NUM_MST_PORTS-1:0]            mst_aw_valid_o;
  logic [NUM_MST_PORTS-1:0]            mst_aw_ready_i;
  w_chan_t                             mst_w_o;
  logic [NUM_MST_PORTS-1:0]            mst_w_valid_o;
  logic [NUM_MST_PORTS-1:0]            mst_w_ready_i;
  b_chan_t [NUM_MST_PORTS-1:0]         mst_b_i;
  logic [NUM_MST_PORTS-1:0]            mst_b_valid_i;
  logic [NUM_MST_PORTS-1:0]            mst_b_ready_o;

  // Pattern table
  string   pat_name [MAX_PATS];
  id_t     pat_id   [MAX_PATS];
  select_t pat_sel  [MAX_PATS];
  len_t    pat_len  [MAX_PATS];
  data_t   pat_data [MAX_PATS];
  resp_t   pat_resp [MAX_PATS];
  int      num_pats;
  int      total_beats;
  // Pattern indices in issue order per master port
  int      port_pats [NUM_MST_PORTS][MAX_PATS];
  int      port_len  [NUM_MST_PORTS];
  // Progress seen on each master port
  int      aw_cnt  [NUM_MST_PORTS];
  int      w_cnt   [NUM_MST_PORTS];
  int      b_cnt   [NUM_MST_PORTS];
  int      b_shown [NUM_MST_PORTS];
  // AWs taken by a port whose B has not reached the slave yet
  int      out_cnt [NUM_ID_COUNTERS][NUM_MST_PORTS];
  // AWs that passed while their ID was still open on their own port
  int      same_port_cnt;
  int      aw_pat;
  int      w_pat;
  int      w_beat;
  int      b_total;
  logic    aw_held;
  aw_chan_t held_aw;
  select_t held_sel;
  logic    b_held;
  b_chan_t held_b;
  logic    monitor_on;

  axi_write_demux axi_write_demux_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Reporting and compare tasks
  // ------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_level(input string sig, input logic [NUM_MST_PORTS-1:0] actual);
    if (actual !== '0) begin
      report_failure($sformatf("ERROR reset: %s expected 0 actual %h", sig, actual));
    end
  endtask

  task automatic check_aw(input string test, input aw_chan_t exp_aw, input select_t exp_sel,
                          input aw_chan_t act_aw, input select_t act_sel);
    if (exp_aw !== act_aw || exp_sel !== act_sel) begin
      report_failure($sformatf("ERROR %s: AW expected port %0d %h actual port %0d %h",
                               test, exp_sel, exp_aw, act_sel, act_aw));
    end
  endtask

  task automatic check_w(input string test, input w_chan_t exp_w, input select_t exp_sel,
                         input w_chan_t act_w, input select_t act_sel);
    if (exp_w !== act_w || exp_sel !== act_sel) begin
      report_failure($sformatf("ERROR %s: W expected port %0d %h actual port %0d %h",
                               test, exp_sel, exp_w, act_sel, act_w));
    end
  endtask

  task automatic check_b(input string test, input b_chan_t exp_b, input b_chan_t act_b);
    if (exp_b !== act_b) begin
      report_failure($sformatf("ERROR %s: B expected %h actual %h", test, exp_b, act_b));
    end
  endtask

  function automatic aw_chan_t expected_aw(input int i);
    aw_chan_t aw;
    aw.id   = pat_id[i];
    aw.addr = 32'h1000_0000 + addr_t'(i) * 32'h40;
    aw.len  = pat_len[i];
    return aw;
  endfunction

  function automatic w_chan_t expected_w(input int i, input int j);
    w_chan_t w;
    w.data = pat_data[i] + data_t'(j);
    w.strb = '1;
    w.last = (j == int'(pat_len[i]));
    return w;
  endfunction

  task automatic load_patterns();
    int      fd;
    string   line;
    string   name;
    id_t     id;
    select_t sel;
    len_t    len;
    data_t   data;
    resp_t   resp;
    fd = $fopen("bench/demux_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the pattern file bench/demux_patterns.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#" &&
          $sscanf(line, "%s %h %h %h %h %h", name, id, sel, len, data, resp) == 6) begin
        pat_name[num_pats] = name;
        pat_id[num_pats]   = id;
        pat_sel[num_pats]  = sel;
        pat_len[num_pats]  = len;
        pat_data[num_pats] = data;
        pat_resp[num_pats] = resp;
        port_pats[sel][port_len[sel]] = num_pats;
        port_len[sel]++;
        total_beats += int'(len) + 1;
        num_pats++;
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------------------
  // Slave side drivers
  // ------------------------------------------------------------
  task automatic send_aws();
    for (int i = 0; i < num_pats; i++) begin
      slv_aw_i        = expected_aw(i);
      slv_aw_select_i = pat_sel[i];
      slv_aw_valid_i  = 1'b1;
      @(posedge clk_i);
      while (!slv_aw_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      slv_aw_valid_i = 1'b0;
      while (($urandom % 4) == 0) @(negedge clk_i);
    end
  endtask

  task automatic send_ws();
    for (int i = 0; i < num_pats; i++) begin
      for (int j = 0; j <= int'(pat_len[i]); j++) begin
        slv_w_i       = expected_w(i, j);
        slv_w_valid_i = 1'b1;
        @(posedge clk_i);
        while (!slv_w_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        slv_w_valid_i = 1'b0;
        while (($urandom % 4) == 0) @(negedge clk_i);
      end
    end
  endtask

  // Master port models answer a burst only after its AW and W
  task automatic drive_masters();
    int      k;
    b_chan_t b;
    slv_b_ready_i = ($urandom % 4) != 0;
    for (int p = 0; p < NUM_MST_PORTS; p++) begin
      mst_aw_ready_i[p] = ($urandom % 3) != 0;
      mst_w_ready_i[p]  = ($urandom % 4) != 0;
      if (!(mst_b_valid_i[p] && b_shown[p] == b_cnt[p])) begin
        mst_b_valid_i[p] = 1'b0;
        if (aw_cnt[p] > b_cnt[p] && w_cnt[p] > b_cnt[p] && ($urandom % 2) == 0) begin
          k                = port_pats[p][b_cnt[p]];
          b.id             = pat_id[k];
          b.resp           = pat_resp[k];
          mst_b_i[p]       = b;
          mst_b_valid_i[p] = 1'b1;
          b_shown[p]       = b_cnt[p];
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Monitors sampling on the rising edge
  // ------------------------------------------------------------
  task automatic watch_aw();
    int       n;
    select_t  act_sel;
    aw_chan_t exp_aw;
    look_id_t look;
    n = 0;
    for (int q = 0; q < NUM_MST_PORTS; q++) begin
      if (mst_aw_valid_o[q]) begin
        n++;
        act_sel = select_t'(q);
      end
    end
    if (n > 1) report_failure("More than one master AW valid is high");
    if (aw_held) begin
      if (n != 1) report_failure("Master AW valid dropped before its transfer");
      check_aw(pat_name[aw_pat], held_aw, held_sel, mst_aw_o, act_sel);
    end
    aw_held = 1'b0;
    if (n == 1) begin
      if (aw_pat >= num_pats) report_failure("Master AW valid with no AW pending");
      exp_aw = expected_aw(aw_pat);
      look   = exp_aw.id[ID_LOOK_BITS-1:0];
      for (int q = 0; q < NUM_MST_PORTS; q++) begin
        if (select_t'(q) != act_sel && out_cnt[look][q] != 0) begin
          report_failure($sformatf("Test %s: AW on port %0d while ID %0h is open on port %0d",
                                   pat_name[aw_pat], act_sel, exp_aw.id, q));
        end
      end
      if (mst_aw_ready_i[act_sel]) begin
        check_aw(pat_name[aw_pat], exp_aw, pat_sel[aw_pat], mst_aw_o, act_sel);
        if (out_cnt[look][act_sel] != 0) begin
          same_port_cnt++;
        end
        out_cnt[look][act_sel]++;
        aw_cnt[act_sel]++;
        aw_pat++;
      end else begin
        aw_held  = 1'b1;
        held_aw  = mst_aw_o;
        held_sel = act_sel;
      end
    end
  endtask

  task automatic watch_w();
    int      n;
    select_t act_sel;
    n = 0;
    for (int q = 0; q < NUM_MST_PORTS; q++) begin
      if (mst_w_valid_o[q]) begin
        n++;
        act_sel = select_t'(q);
      end
    end
    if (n > 1) report_failure("More than one master W valid is high");
    if (n == 1 && mst_w_ready_i[act_sel]) begin
      if (w_pat >= num_pats) report_failure("Master W beat with no burst pending");
      check_w(pat_name[w_pat], expected_w(w_pat, w_beat), pat_sel[w_pat], mst_w_o, act_sel);
      if (w_beat == int'(pat_len[w_pat])) begin
        w_cnt[act_sel]++;
        w_pat++;
        w_beat = 0;
      end else begin
        w_beat++;
      end
    end
  endtask

  task automatic watch_b();
    int      n;
    int      p;
    int      k;
    b_chan_t exp_b;
    n = 0;
    p = 0;
    for (int q = 0; q < NUM_MST_PORTS; q++) begin
      if (mst_b_valid_i[q] && mst_b_ready_o[q]) begin
        n++;
        p = q;
      end
    end
    if (b_held) begin
      if (!slv_b_valid_o) report_failure("Slave B valid dropped while ready was low");
      check_b("b_stall", held_b, slv_b_o);
    end
    b_held = 1'b0;
    if (slv_b_valid_o && slv_b_ready_i) begin
      if (n != 1) report_failure("Slave B transfer without exactly one master B transfer");
      if (b_cnt[p] >= port_len[p]) report_failure("B taken from a port with no burst open");
      k          = port_pats[p][b_cnt[p]];
      exp_b.id   = pat_id[k];
      exp_b.resp = pat_resp[k];
      check_b(pat_name[k], exp_b, slv_b_o);
      out_cnt[pat_id[k][ID_LOOK_BITS-1:0]][p]--;
      b_cnt[p]++;
      b_total++;
    end else begin
      if (n != 0) report_failure("Master B taken without a slave B transfer");
      if (slv_b_valid_o) begin
        b_held = 1'b1;
        held_b = slv_b_o;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (monitor_on) begin
      watch_aw();
      watch_w();
      watch_b();
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin : main_seq
    int unsigned seed_val;
    seed_val        = $urandom(47454);
    rst_n_i         = 1'b0;
    slv_aw_i        = '0;
    slv_aw_select_i = '0;
    slv_aw_valid_i  = 1'b0;
    slv_w_i         = '0;
    slv_w_valid_i   = 1'b0;
    slv_b_ready_i   = 1'b0;
    mst_aw_ready_i  = '0;
    mst_w_ready_i   = '0;
    mst_b_i         = '0;
    mst_b_valid_i   = '0;
    monitor_on      = 1'b0;
    aw_held         = 1'b0;
    b_held          = 1'b0;
    aw_pat          = 0;
    w_pat           = 0;
    w_beat          = 0;
    b_total         = 0;
    same_port_cnt   = 0;
    load_patterns();
    // First W beat already waits at the slave port through reset
    if (num_pats > 0) begin
      slv_w_i       = expected_w(0, 0);
      slv_w_valid_i = 1'b1;
    end
    fork
      begin
        repeat (total_beats * 50) @(posedge clk_i);
        report_failure($sformatf("Timeout: responses still missing after %0d cycles",
                                 total_beats * 50));
      end
      forever begin
        @(negedge clk_i);
        drive_masters();
      end
    join_none
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    check_level("slv_aw_ready_o", slv_aw_ready_o);
    check_level("slv_b_valid_o", slv_b_valid_o);
    check_level("mst_aw_valid_o", mst_aw_valid_o);
    check_level("mst_w_valid_o", mst_w_valid_o);
    check_level("mst_b_ready_o", mst_b_ready_o);
    @(negedge clk_i);
    monitor_on = 1'b1;
    fork
      send_aws();
      send_ws();
    join
    while (b_total < num_pats) @(negedge clk_i);
    // Quiet period to catch stray responses
    repeat (10) @(negedge clk_i);
    for (int p = 0; p < NUM_MST_PORTS; p++) begin
      if (b_cnt[p] != port_len[p]) begin
        report_failure($sformatf("Port %0d returned %0d responses, %0d expected",
                                 p, b_cnt[p], port_len[p]));
      end
    end
    if (aw_pat != num_pats || w_pat != num_pats) begin
      report_failure($sformatf("Only %0d AWs and %0d W bursts of %0d reached the masters",
                               aw_pat, w_pat, num_pats));
    end
    if (same_port_cnt == 0) begin
      report_failure("No same-ID AW reached a port while its ID was open on that port");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

// ==== project.f ====
source/axi_demux_pkg.sv
source/demux_id_table.sv
source/demux_aw_control.sv
source/demux_w_router.sv
source/demux_b_arbiter.sv
source/axi_write_demux.sv
bench/axi_write_demux_tb.sv

// ==== bench/demux_patterns.txt ====
# Columns: test_name id(hex) select(hex) len(hex) first_data(hex) resp(hex)
# A burst has len+1 beats, its data counts up from first_data
route_p0      0 0 0 a0000000 0
route_p1      1 1 1 a1000000 0
route_p2      2 2 3 a2000000 1
route_p3      3 3 0 a3000000 2
same_port_a   5 1 2 b0000000 0
same_port_b   5 1 0 b1000000 3
same_port_c   d 1 1 b2000000 0
cross_port_a  6 2 3 c0000000 0
cross_port_b  6 0 0 c1000000 1
cross_port_c  e 3 1 c2000000 0
cross_port_d  2 1 2 c3000000 2
long_burst_0  8 0 7 d0000000 0
long_burst_3  b 3 5 d1000000 3
single_beat_a 4 2 0 e0000000 0
single_beat_b 9 2 0 e1000000 1
single_beat_c c 0 0 e2000000 0
single_beat_d 1 3 0 e3000000 0
burst_mix_a   7 1 4 f0000000 2
burst_mix_b   f 2 2 f1000000 0
burst_mix_c   3 3 3 f2000000 1
fill_id_0     0 0 1 f3000000 0
fill_id_1     4 0 1 f4000000 0
fill_id_2     8 0 1 f5000000 0
fill_id_3     c 0 1 f6000000 3
fill_id_4     0 0 0 f7000000 0
fill_id_5     4 0 0 f8000000 0
fill_id_6     8 0 0 f9000000 0
fill_id_7     c 0 0 fa000000 0
switch_id     0 2 1 fb000000 1
